// File: common/pipe_pkg.sv
package pipe_pkg;

  ////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////

  // One fetched word with its address
  typedef struct packed {
    logic [31:0]         pc;
    rv_isa_pkg::instr_u  ins;
  } fetch_entry_t;

  // Taken branch or jump, back to fetch
  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } redirect_t;

  ////////////////////////////////////////////////////////////
  // Decode output and writeback
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    rv_isa_pkg::alu_op_e alu_op;
    logic                alusrc;
    logic                regwrite;
    logic                memread;
    logic                memwrite;
    logic                branch;
    logic                jal;
    logic                jalr;
    logic                lui;
    logic                auipc;
    logic                ecall;
    logic                illegal;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    ctrl_t       ctrl;
  } id_ex_t;

  // Register write from the later stages
  typedef struct packed {
    logic        en;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

endpackage

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Major opcodes of the kept RV32I subset
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // Branch conditions in funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  ////////////////////////////////////////////////////////////
  // Instruction formats, one view each of the same word
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fmt_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } fmt_s_t;

  // Scrambled branch offset, bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } fmt_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fmt_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_j_t;

  typedef union packed {
    fmt_r_t r;
    fmt_i_t i;
    fmt_s_t s;
    fmt_b_t b;
    fmt_u_t u;
    fmt_j_t j;
  } instr_u;

  // Operation for the execute stage ALU
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

endpackage

// File: decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                   bus,
  input  logic                   arst_n,
  input  pipe_pkg::fetch_entry_t head,
  input  logic                   empty,
  input  logic                   ex_hold,
  input  pipe_pkg::wb_t          wb,
  output logic                   pop,
  output pipe_pkg::redirect_t    redirect,
  output pipe_pkg::id_ex_t       id_ex,
  output logic                   id_ex_valid
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  instr_u      ins;
  logic [31:0] imm;
  ctrl_t       ctrl;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        cond;

  // Register-register and register-immediate share the funct3 map
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign ins = head.ins;
  assign pop = !empty && !ex_hold;

  reg_file i_reg_file (
    .bus     (bus),
    .arst_n  (arst_n),
    .rs1     (ins.r.rs1),
    .rs2     (ins.r.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wb      (wb)
  );

  ////////////////////////////////////////////////////////////
  // Immediate and control
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (ins.r.opcode)
      op_lui, op_auipc: imm = {ins.u.imm_31_12, 12'h000};
      op_jal: imm = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
                     ins.j.imm_11, ins.j.imm_10_1, 1'b0};
      op_branch: imm = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                        ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
      op_store: imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
      op_op: imm = '0;
      default: imm = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    case (ins.r.opcode)
      op_lui: begin
        ctrl.alu_op   = alu_pass_b;
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.lui      = 1'b1;
      end
      op_auipc: begin
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.auipc    = 1'b1;
      end
      op_jal: begin
        ctrl.regwrite = 1'b1;
        ctrl.jal      = 1'b1;
      end
      op_jalr: begin
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.jalr     = 1'b1;
      end
      op_branch: begin
        ctrl.alu_op = alu_sub;
        ctrl.branch = 1'b1;
      end
      op_load: begin
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.memread  = 1'b1;
      end
      op_store: begin
        ctrl.alusrc   = 1'b1;
        ctrl.memwrite = 1'b1;
      end
      op_imm: begin
        // Only srai uses bit 30, addi has no subtract form
        ctrl.alu_op   = alu_sel(ins.r.funct3, ins.r.funct7[5] && ins.r.funct3 == 3'b101);
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      op_op: begin
        ctrl.alu_op   = alu_sel(ins.r.funct3, ins.r.funct7[5]);
        ctrl.regwrite = 1'b1;
      end
      op_system: ctrl.ecall = (ins == 32'h0000_0073);
      default: ctrl.illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Branch decision and redirect
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (ins.b.funct3)
      f3_beq:  cond = (rs1_val == rs2_val);
      f3_bne:  cond = (rs1_val != rs2_val);
      f3_blt:  cond = ($signed(rs1_val) < $signed(rs2_val));
      f3_bge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
      f3_bltu: cond = (rs1_val < rs2_val);
      f3_bgeu: cond = (rs1_val >= rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign redirect.taken  = pop && (ctrl.jal || ctrl.jalr || (ctrl.branch && cond));
  assign redirect.target = ctrl.jalr ? ((rs1_val + imm) & ~32'h1) : (head.pc + imm);

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_valid <= 1'b0;
    end else begin
      id_ex_valid <= pop;
    end
  end

  // Contents hold between packets
  always_ff @(posedge bus) begin
    if (pop) begin
      id_ex.pc      <= head.pc;
      id_ex.rs1     <= ins.r.rs1;
      id_ex.rs2     <= ins.r.rs2;
      id_ex.rd      <= ins.r.rd;
      id_ex.rs1_val <= rs1_val;
      id_ex.rs2_val <= rs2_val;
      id_ex.imm     <= imm;
      id_ex.ctrl    <= ctrl;
    end
  end

endmodule

// File: decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic          bus,
  input  logic          arst_n,
  input  logic [4:0]    rs1,
  input  logic [4:0]    rs2,
  output logic [31:0]   rs1_val,
  output logic [31:0]   rs2_val,
  input  pipe_pkg::wb_t wb
);

  import pipe_pkg::*;

  // x1 to x31, x0 has no storage
  logic [31:0] regs [1:31];

  // Same-cycle write is forwarded to the reader
  function automatic logic [31:0] read_reg(input logic [4:0] rs);
    if (rs == 5'd0) begin
      return '0;
    end
    if (wb.en && wb.rd == rs) begin
      return wb.data;
    end
    return regs[rs];
  endfunction

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_val = read_reg(rs1);
  assign rs2_val = read_reg(rs2);

endmodule

// File: fetch/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
  parameter int buf_depth = 4
) (
  input  logic                   bus,
  input  logic                   arst_n,
  input  logic                   push,
  input  pipe_pkg::fetch_entry_t entry,
  input  logic                   pop,
  input  logic                   flush,
  output pipe_pkg::fetch_entry_t head,
  output logic                   empty,
  output logic                   full
);

  import pipe_pkg::*;

  localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
  localparam int cnt_w = $clog2(buf_depth + 1);

  fetch_entry_t     mem [buf_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Wraps at buf_depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(buf_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign wr_en = push && !full && !flush;
  assign rd_en = pop && !empty;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge bus) begin
    if (wr_en) begin
      mem[wr_ptr] <= entry;
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(buf_depth));

endmodule

// File: fetch/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                   bus,
  input  logic                   arst_n,
  output logic [31:0]            imem_addr,
  input  logic [31:0]            imem_data,
  input  logic                   full,
  input  pipe_pkg::redirect_t    redirect,
  output logic                   push,
  output pipe_pkg::fetch_entry_t entry
);

  import pipe_pkg::*;

  logic [31:0] pc;
  logic        run;

  // Fetch starts one cycle after reset is released
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (push) begin
      pc <= pc + 32'd4;
    end
  end

  // Stall on a full buffer, drop the word of a redirect cycle
  assign push = run && !full && !redirect.taken;

  // Memory answers in the same cycle
  assign imem_addr = pc;
  assign entry.pc  = pc;
  assign entry.ins = imem_data;

endmodule

// File: project.f
common/rv_isa_pkg.sv
common/pipe_pkg.sv
fetch/fetch_stage.sv
fetch/fetch_buffer.sv
decode/reg_file.sv
decode/decode_stage.sv
verilog/rv_front_top.sv
test/rv_front_props.sv
test/rv_front_checker.sv
test/tb_rv_front.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_front \
  -f project.f -o sim_rv_front
./obj_dir/sim_rv_front +verilator+error+limit+1000 | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
echo "Run failed, see sim.log"
exit 1

// File: test/rv_front_checker.sv
`timescale 1ns/1ps

module rv_front_checker #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic             bus,
  input  logic             arst_n,
  input  logic             ex_hold,
  input  pipe_pkg::wb_t    wb,
  input  pipe_pkg::id_ex_t id_ex,
  input  logic             id_ex_valid,
  input  logic [31:0]      prog [256],
  output int               packets,
  output int               errors
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [31:0] regs [32];
  logic [31:0] exp_pc;
  logic        hold_q;
  int          pkt_cnt = 0;
  int          err_cnt = 0;

  assign packets = pkt_cnt;
  assign errors  = err_cnt;

  function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    return $unsigned($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  function automatic logic [31:0] exp_imm(input instr_u w);
    case (w.r.opcode)
      op_lui, op_auipc: return {w.u.imm_31_12, 12'h000};
      op_jal: return sext({11'h0, w.j.imm_20, w.j.imm_19_12, w.j.imm_11,
                           w.j.imm_10_1, 1'b0}, 21);
      op_branch: return sext({19'h0, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                              w.b.imm_4_1, 1'b0}, 13);
      op_store: return sext({20'h0, w.s.imm_11_5, w.s.imm_4_0}, 12);
      op_op: return 32'h0;
      default: return sext({20'h0, w.i.imm_11_0}, 12);
    endcase
  endfunction

  // funct3 order of the base ALU operations
  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    alu_op_e base [8];
    base = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and};
    if (alt && f3 == 3'b000) begin
      return alu_sub;
    end
    if (alt && f3 == 3'b101) begin
      return alu_sra;
    end
    return base[f3];
  endfunction

  // Each flag from the set of opcodes that need it
  function automatic ctrl_t exp_ctrl(input instr_u w);
    ctrl_t      c;
    logic [6:0] op;
    op = w.r.opcode;
    c  = '0;
    c.lui      = (op == op_lui);
    c.auipc    = (op == op_auipc);
    c.jal      = (op == op_jal);
    c.jalr     = (op == op_jalr);
    c.branch   = (op == op_branch);
    c.memread  = (op == op_load);
    c.memwrite = (op == op_store);
    c.ecall    = (w == 32'h0000_0073);
    c.illegal  = !(op inside {op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load,
                              op_store, op_imm, op_op, op_system});
    c.regwrite = op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_op};
    c.alusrc   = op inside {op_lui, op_auipc, op_jalr, op_load, op_store, op_imm};
    if (op == op_lui) begin
      c.alu_op = alu_pass_b;
    end else if (op == op_branch) begin
      c.alu_op = alu_sub;
    end else if (op == op_imm) begin
      // Bit 30 selects sra for shifts only
      c.alu_op = alu_of(w.r.funct3, w.r.funct7[5] && w.r.funct3 == 3'b101);
    end else if (op == op_op) begin
      c.alu_op = alu_of(w.r.funct3, w.r.funct7[5]);
    end else begin
      c.alu_op = alu_add;
    end
    return c;
  endfunction

  function automatic logic cond_holds(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      f3_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_field(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: pc %h %s is %h, expected %h",
               $time, exp_pc, what, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model of program order and register state
  ////////////////////////////////////////////////////////////
  always @(posedge bus or negedge arst_n) begin
    instr_u      w;
    ctrl_t       c;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
      end
      exp_pc = reset_pc;
      hold_q = 1'b0;
    end else begin
      if (id_ex_valid) begin
        pkt_cnt++;
        if (hold_q) begin
          $display("Packet issued at %0t in the cycle after ex_hold was high", $time);
          err_cnt++;
        end
        check_field("pc", id_ex.pc, exp_pc);
        // Follow the DUT after a pc mismatch
        exp_pc = id_ex.pc;
        w      = prog[exp_pc[9:2]];
        imm    = exp_imm(w);
        c      = exp_ctrl(w);
        // Model registers already hold the pop cycle's writeback
        a      = regs[w.r.rs1];
        b      = regs[w.r.rs2];
        check_field("rs1", 32'(id_ex.rs1), 32'(w.r.rs1));
        check_field("rs2", 32'(id_ex.rs2), 32'(w.r.rs2));
        check_field("rd", 32'(id_ex.rd), 32'(w.r.rd));
        check_field("rs1_val", id_ex.rs1_val, a);
        check_field("rs2_val", id_ex.rs2_val, b);
        check_field("imm", id_ex.imm, imm);
        check_field("ctrl", 32'(id_ex.ctrl), 32'(c));
        taken = c.jal || c.jalr || (c.branch && cond_holds(w.b.funct3, a, b));
        if (taken && c.jalr) begin
          exp_pc = (a + imm) & ~32'h1;
        end else if (taken) begin
          exp_pc = exp_pc + imm;
        end else begin
          exp_pc = exp_pc + 32'd4;
        end
      end
      if (wb.en && wb.rd != 5'd0) begin
        regs[wb.rd] = wb.data;
      end
      hold_q = ex_hold;
    end
  end

endmodule

// File: test/rv_front_props.sv
`timescale 1ns/1ps

module rv_front_props (
  input logic bus,
  input logic arst_n,
  input logic push,
  input logic full,
  input logic empty,
  input logic redirect_taken,
  input logic id_ex_valid
);

  // Count of failed assertions
  int fails = 0;

  // First cycle out of reset carries no packet
  assert property (@(posedge bus) $rose(arst_n) |-> !id_ex_valid)
    else begin
      $error("id_ex_valid high in the first cycle after reset");
      fails++;
    end

  assert property (@(posedge bus) disable iff (!arst_n) push |-> !full && !redirect_taken)
    else begin
      $error("fetch pushed while the buffer was full or a redirect was taken");
      fails++;
    end

  assert property (@(posedge bus) disable iff (!arst_n) !(empty && full))
    else begin
      $error("fetch buffer reports empty and full together");
      fails++;
    end

  ////////////////////////////////////////////////////////////
  // Redirect
  ////////////////////////////////////////////////////////////

  // Younger words are gone after a taken redirect
  assert property (@(posedge bus) disable iff (!arst_n) redirect_taken |=> empty)
    else begin
      $error("fetch buffer not empty after a taken redirect");
      fails++;
    end

endmodule

// File: test/tb_rv_front.sv
`timescale 1ns/1ps

module tb_rv_front;

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int          num_tests     = 3;
  localparam int          pkts_per_test = 200;
  localparam int          max_cycles    = 4 * num_tests * pkts_per_test + 100;
  localparam int          buf_depth     = 4;
  localparam logic [31:0] reset_pc      = 32'h0000_0040;

  logic        bus;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  wb_t         wb;
  logic        ex_hold;
  id_ex_t      id_ex;
  logic        id_ex_valid;
  logic [31:0] prog [256];
  logic [31:0] junk;
  int          seed;
  int          packets;
  int          errors;
  int          cycles;
  int          prop_fails;

  rv_front_top #(
    .buf_depth (buf_depth),
    .reset_pc  (reset_pc)
  ) i_rv_front_top (
    .bus         (bus),
    .arst_n      (arst_n),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .wb          (wb),
    .ex_hold     (ex_hold),
    .id_ex       (id_ex),
    .id_ex_valid (id_ex_valid)
  );

  rv_front_checker #(
    .reset_pc (reset_pc)
  ) i_checker (
    .bus         (bus),
    .arst_n      (arst_n),
    .ex_hold     (ex_hold),
    .wb          (wb),
    .id_ex       (id_ex),
    .id_ex_valid (id_ex_valid),
    .prog        (prog),
    .packets     (packets),
    .errors      (errors)
  );

  bind rv_front_top rv_front_props i_props (
    .bus            (bus),
    .arst_n         (arst_n),
    .push           (push),
    .full           (full),
    .empty          (empty),
    .redirect_taken (redirect.taken),
    .id_ex_valid    (id_ex_valid)
  );

  // Instruction memory, junk outside the program
  assign imem_data = (imem_addr < 32'd1024) ? prog[imem_addr[9:2]] : junk;

  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [31:0] jal_word(input logic [31:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  ////////////////////////////////////////////////////////////
  // Random program generation
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] random_instr(input int idx);
    logic [31:0] r;
    logic [31:0] off;
    logic [31:0] kind;
    logic [2:0]  f3;
    r    = rand_word();
    // Byte offset to a random word of the program
    off  = 32'((int'(rand_word() & 32'hff) - idx) * 4);
    kind = rand_word() % 32'd12;
    f3   = r[14:12];
    case (kind)
      0: return {r[31:7], op_lui};
      1: return {r[31:7], op_auipc};
      2: return jal_word(off, r[11:7]);
      // Absolute target from x0
      3: return {2'b00, r[27:20], 2'b00, 5'd0, 3'b000, r[11:7], op_jalr};
      4, 5: begin
        // funct3 010 and 011 are no branches
        if (f3[2:1] == 2'b01) begin
          f3 = f3 ^ 3'b110;
        end
        return {off[12], off[10:5], r[24:15], f3, off[4:1], off[11], op_branch};
      end
      6: return {r[31:15], f3, r[11:7], op_load};
      7: return {r[31:7], op_store};
      8: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          return {1'b0, r[30] && f3 == 3'b101, 5'b0, r[24:15], f3, r[11:7], op_imm};
        end
        return {r[31:7], op_imm};
      end
      9: return {1'b0, r[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, r[24:15], f3,
                 r[11:7], op_op};
      10: return r[0] ? 32'h0000_0073 : 32'h0010_0073;
      default: return {r[31:7], r[6:5], 5'b01011};
    endcase
  endfunction

  task automatic fill_program();
    for (int i = 0; i < 255; i++) begin
      prog[i] = random_instr(i);
    end
    // Last word wraps to the start of memory
    prog[255] = jal_word(32'(-1020), 5'd0);
  endtask

  task automatic apply_reset();
    arst_n  = 1'b0;
    ex_hold = 1'b0;
    wb      = '0;
    fill_program();
    repeat (2) @(negedge bus);
    arst_n = 1'b1;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r       = rand_word();
    ex_hold = (r[2:1] == 2'b00);
    wb.en   = r[0];
    wb.rd   = r[7:3];
    wb.data = rand_word();
    junk    = rand_word();
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge bus);
      cycles++;
    end
    $display("Timeout: only %0d packets seen after %0d cycles", packets, cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : run_tests
    int start_pkts;
    int start_errs;
    seed    = 32'h813c;
    arst_n  = 1'b0;
    ex_hold = 1'b0;
    wb      = '0;
    junk    = '0;
    for (int t = 1; t <= num_tests; t++) begin
      apply_reset();
      start_pkts = packets;
      start_errs = errors;
      while (packets - start_pkts < pkts_per_test) begin
        @(negedge bus);
        drive_inputs();
      end
      $display("Test %0d, random program from pc %h: %0d packets, %0d errors",
               t, reset_pc, packets - start_pkts, errors - start_errs);
    end
    prop_fails = i_rv_front_top.i_props.fails;
    $display("Tests %0d, packets %0d, check errors %0d, assertion failures %0d",
             num_tests, packets, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/rv_front_top.sv
`timescale 1ns/1ps

module rv_front_top #(
  parameter int          buf_depth = 4,
  parameter logic [31:0] reset_pc  = 32'h0000_0000
) (
  input  logic             bus,
  input  logic             arst_n,
  output logic [31:0]      imem_addr,
  input  logic [31:0]      imem_data,
  input  pipe_pkg::wb_t    wb,
  input  logic             ex_hold,
  output pipe_pkg::id_ex_t id_ex,
  output logic             id_ex_valid
);

  import pipe_pkg::*;

  logic         push;
  logic         full;
  logic         empty;
  logic         pop;
  fetch_entry_t entry;
  fetch_entry_t head;
  redirect_t    redirect;

  fetch_stage #(
    .reset_pc (reset_pc)
  ) i_fetch_stage (
    .bus       (bus),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .full      (full),
    .redirect  (redirect),
    .push      (push),
    .entry     (entry)
  );

  // A taken redirect empties the buffer of younger words
  fetch_buffer #(
    .buf_depth (buf_depth)
  ) i_fetch_buffer (
    .bus    (bus),
    .arst_n (arst_n),
    .push   (push),
    .entry  (entry),
    .pop    (pop),
    .flush  (redirect.taken),
    .head   (head),
    .empty  (empty),
    .full   (full)
  );

  decode_stage i_decode_stage (
    .bus         (bus),
    .arst_n      (arst_n),
    .head        (head),
    .empty       (empty),
    .ex_hold     (ex_hold),
    .wb          (wb),
    .pop         (pop),
    .redirect    (redirect),
    .id_ex       (id_ex),
    .id_ex_valid (id_ex_valid)
  );

endmodule
